/* dv/tb_anpc_ref.svh */
`ifndef TB_ANPC_REF_SVH
`define TB_ANPC_REF_SVH

// Delay codes used in the step lists
localparam logic [1:0] D_SH = 2'd0;  // t_short
localparam logic [1:0] D_OO = 2'd1;  // t_off_on
localparam logic [1:0] D_V0 = 2'd2;  // t_on_off_v0
localparam logic [1:0] D_I0 = 2'd3;  // t_off_on_i0

function automatic logic [`GATE_WIDTH-1:0] steady_pattern(input anpc_state_t s);
    case (s)
        ST_P:    return 6'b110_001;
        ST_ZU1:  return 6'b010_110;
        ST_ZL1:  return 6'b101_001;
        ST_ZL2:  return 6'b001_001;
        ST_N:    return 6'b001_110;
        default: return 6'b010_010;
    endcase
endfunction

function automatic anpc_state_t target_state(input anpc_state_t s, input level_t l,
                                             input comm_type_t c);
    if (s != ST_P && s != ST_N) begin
        // Zero states only leave for an active level
        if (l == LEV_POS) return ST_P;
        if (l == LEV_NEG) return ST_N;
        return s;
    end
    if (l != LEV_ZERO) return s;
    case (c)
        COMM_II:  return (s == ST_P) ? ST_ZL2 : ST_ZU2;
        COMM_III: return (s == ST_P) ? ST_ZL1 : ST_ZU1;
        default:  return (s == ST_P) ? ST_ZU2 : ST_ZL2;  // Type I and code 3
    endcase
endfunction

// Four slots of gate pattern and delay code, unused slots zero
function automatic logic [31:0] sequence_code(input anpc_state_t src, input anpc_state_t dst);
    case ({src, dst})
        {ST_ZU2, ST_P}: return {6'b010_000, D_OO, 6'b110_000, D_SH, 6'b110_001, D_SH, 8'd0};
        {ST_ZU2, ST_N}: return {6'b011_010, D_SH, 6'b001_010, D_OO, 6'b001_110, D_SH, 8'd0};
        {ST_ZU1, ST_P}: return {6'b010_010, D_I0, 6'b010_011, D_SH,
                                6'b010_001, D_OO, 6'b110_001, D_SH};
        {ST_ZU1, ST_N}: return {6'b000_110, D_OO, 6'b001_110, D_SH, 16'd0};
        {ST_ZL1, ST_P}: return {6'b100_001, D_OO, 6'b110_001, D_SH, 16'd0};
        {ST_ZL1, ST_N}: return {6'b001_001, D_I0, 6'b001_011, D_SH,
                                6'b001_010, D_OO, 6'b001_110, D_SH};
        {ST_ZL2, ST_P}: return {6'b011_001, D_SH, 6'b010_001, D_OO, 6'b110_001, D_SH, 8'd0};
        {ST_ZL2, ST_N}: return {6'b001_000, D_OO, 6'b001_100, D_SH, 6'b001_110, D_SH, 8'd0};
        {ST_P, ST_ZU2}: return {6'b110_000, D_SH, 6'b010_000, D_OO, 6'b010_010, D_SH, 8'd0};
        {ST_P, ST_ZL1}: return {6'b100_001, D_OO, 6'b101_001, D_SH, 16'd0};
        {ST_P, ST_ZL2}: return {6'b010_001, D_OO, 6'b011_001, D_SH, 6'b001_001, D_SH, 8'd0};
        {ST_N, ST_ZU2}: return {6'b001_010, D_OO, 6'b011_010, D_V0, 6'b010_010, D_SH, 8'd0};
        {ST_N, ST_ZU1}: return {6'b000_110, D_OO, 6'b010_110, D_SH, 16'd0};
        {ST_N, ST_ZL2}: return {6'b001_100, D_SH, 6'b001_000, D_OO, 6'b001_001, D_SH, 8'd0};
        default:        return 32'd0;
    endcase
endfunction

// Appends one expected gates value per cycle of the dead-time sequence
function automatic void expand_commutation(input anpc_state_t src, input anpc_state_t dst);
    logic [31:0] code;
    logic [7:0]  ent;
    int          dwell;
    code = sequence_code(src, dst);
    for (int k = 0; k < 4; k++) begin
        ent = code[31-8*k -: 8];
        case (ent[1:0])
            D_OO:    dwell = int'(t_off_on);
            D_V0:    dwell = int'(t_on_off_v0);
            D_I0:    dwell = int'(t_off_on_i0);
            default: dwell = int'(t_short);
        endcase
        if (ent[7:2] == 6'b0) dwell = 0;  // Empty slot
        for (int c = 0; c < dwell; c++) exp_q.push_back(ent[7:2]);
    end
endfunction

`endif

/* dv/tb_anpc.sv */
`timescale 1ns/100ps

`include "anpc_defines.svh"

module tb_anpc
    import anpc_state_pkg::*;
();

    localparam int TIMEOUT_CYCLES = 200;

    logic                     clk;
    logic                     rst;
    logic [`TDELAY_WIDTH-1:0] t_short;
    logic [`TDELAY_WIDTH-1:0] t_off_on;
    logic [`TDELAY_WIDTH-1:0] t_on_off_v0;
    logic [`TDELAY_WIDTH-1:0] t_off_on_i0;
    level_t                   lev;
    comm_type_t               comm_type;
    logic [`GATE_WIDTH-1:0]   gates;

    logic [`GATE_WIDTH-1:0]   exp_q[$];  // Expected gates, one entry per cycle
    logic [`GATE_WIDTH-1:0]   exp_gates = `GATE_RESET;
    anpc_state_t              ref_state = ST_ZU2;

    `include "tb_anpc_ref.svh"

    anpc_gate_ctrl_top u_dut (
        .clk         (clk),
        .rst         (rst),
        .t_short     (t_short),
        .t_off_on    (t_off_on),
        .t_on_off_v0 (t_on_off_v0),
        .t_off_on_i0 (t_off_on_i0),
        .lev         (lev),
        .comm_type   (comm_type),
        .gates       (gates)
    );

    always #10 clk = ~clk;

    ////////////////////////////////////////
    // Reference model and comparison
    ////////////////////////////////////////

    always @(posedge clk) begin
        anpc_state_t nxt;
        if (rst) begin
            exp_q.delete();
            ref_state = ST_ZU2;
            exp_gates = `GATE_RESET;
        end else if (exp_q.size() > 0) begin
            exp_gates = exp_q.pop_front();  // Commutation running, inputs ignored
        end else begin
            exp_gates = steady_pattern(ref_state);
            nxt = target_state(ref_state, lev, comm_type);
            if (nxt != ref_state) begin
                expand_commutation(ref_state, nxt);
                ref_state = nxt;
            end
        end
    end

    // Gates settle after the rising edge
    always @(negedge clk) begin
        assert (gates === exp_gates) else begin
            $display("MISMATCH at %0t: gates %b, expected %b", $time, gates, exp_gates);
            $display("SIMULATION FAILED");
            $fatal(1, "gate output differs from the reference");
        end
    end

    ////////////////////////////////////////
    // Stimulus tasks
    ////////////////////////////////////////

    task automatic set_delays(input int sh, input int oo, input int v0, input int i0);
        t_short     = `TDELAY_WIDTH'(sh);
        t_off_on    = `TDELAY_WIDTH'(oo);
        t_on_off_v0 = `TDELAY_WIDTH'(v0);
        t_off_on_i0 = `TDELAY_WIDTH'(i0);
    endtask

    task automatic wait_settled(input anpc_state_t want);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while ((exp_q.size() != 0 || gates !== steady_pattern(want))
               && cycles < TIMEOUT_CYCLES) begin
            cycles++;
            @(negedge clk);
        end
        assert (exp_q.size() == 0 && gates === steady_pattern(want)) else begin
            $display("ERROR at %0t: commutation to %s never completed", $time, want.name());
            $display("SIMULATION FAILED");
            $fatal(1, "timeout");
        end
    endtask

    task automatic request_level(input level_t l, input comm_type_t c, input anpc_state_t want);
        lev       = l;
        comm_type = c;
        wait_settled(want);
    endtask

    initial begin
        anpc_state_t want;
        logic [1:0]  lev_bits;
        logic [1:0]  comm_bits;
        void'($urandom(70));
        clk       = 1'b0;
        rst       = 1'b1;
        lev       = LEV_ZERO;
        comm_type = COMM_I;
        set_delays(2, 3, 5, 4);  // Distinct so each step length shows
        repeat (5) @(negedge clk);
        rst = 1'b0;

        // Idle in ZU2 while the level stays zero
        repeat (10) begin
            @(negedge clk);
            assert (gates === `GATE_RESET) else begin
                $display("MISMATCH at %0t: idle gates %b, expected %b", $time, gates,
                         `GATE_RESET);
                $display("SIMULATION FAILED");
                $fatal(1, "idle pattern wrong");
            end
        end

        ////////////////////////////////////////
        // Every reachable transition
        ////////////////////////////////////////
        request_level(LEV_POS, COMM_I, ST_P);
        request_level(LEV_ZERO, COMM_I, ST_ZU2);
        request_level(LEV_NEG, COMM_I, ST_N);
        request_level(LEV_ZERO, COMM_III, ST_ZU1);
        request_level(LEV_POS, COMM_III, ST_P);   // Four steps with t_off_on_i0
        request_level(LEV_ZERO, COMM_III, ST_ZL1);
        request_level(LEV_NEG, COMM_I, ST_N);     // Four steps with t_off_on_i0
        request_level(LEV_ZERO, COMM_I, ST_ZL2);
        request_level(LEV_POS, COMM_I, ST_P);
        request_level(LEV_ZERO, COMM_II, ST_ZL2);
        request_level(LEV_NEG, COMM_II, ST_N);
        request_level(LEV_ZERO, COMM_II, ST_ZU2);  // Uses t_on_off_v0
        request_level(LEV_NEG, COMM_I, ST_N);
        request_level(LEV_ZERO, COMM_III, ST_ZU1);
        request_level(LEV_NEG, COMM_I, ST_N);
        request_level(LEV_ZERO, COMM_I, ST_ZL2);
        request_level(LEV_POS, COMM_I, ST_P);
        request_level(LEV_ZERO, COMM_III, ST_ZL1);
        request_level(LEV_POS, COMM_I, ST_P);
        request_level(LEV_ZERO, comm_type_t'(2'd3), ST_ZU2);  // Unused code acts as type I
        request_level(LEV_NEG, COMM_I, ST_N);
        request_level(LEV_ZERO, comm_type_t'(2'd3), ST_ZL2);
        request_level(level_t'(2'd3), COMM_I, ST_ZL2);       // Hold code

        // Inputs changed mid-sequence
        set_delays(3, 4, 2, 2);
        lev = LEV_POS;
        repeat (2) @(negedge clk);
        lev       = LEV_ZERO;
        comm_type = COMM_II;
        wait_settled(ST_ZL2);  // Via P, then the late request
        request_level(LEV_NEG, COMM_I, ST_N);
        lev       = LEV_ZERO;
        comm_type = COMM_I;
        repeat (2) @(negedge clk);
        comm_type = COMM_III;  // Too late for this commutation
        wait_settled(ST_ZL2);

        ////////////////////////////////////////
        // Random run
        ////////////////////////////////////////
        for (int i = 0; i < 400; i++) begin
            set_delays($urandom_range(8, 1), $urandom_range(8, 1), $urandom_range(8, 1),
                       $urandom_range(8, 1));
            lev_bits  = 2'($urandom_range(3, 0));
            comm_bits = 2'($urandom_range(3, 0));
            want = target_state(ref_state, level_t'(lev_bits), comm_type_t'(comm_bits));
            request_level(level_t'(lev_bits), comm_type_t'(comm_bits), want);
            repeat ($urandom_range(2, 0)) @(negedge clk);
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

/* hdl/anpc_commutation_seq.sv */
`timescale 1ns/100ps

`include "anpc_defines.svh"

module anpc_commutation_seq
    import anpc_seq_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      active,
    input  logic [`GATE_WIDTH-1:0]    step_gates,
    input  logic [`GATE_WIDTH-1:0]    steady_gates,
    input  dly_sel_t                  dly_sel,
    input  logic                      last_step,
    input  logic [`TDELAY_WIDTH-1:0]  t_short,
    input  logic [`TDELAY_WIDTH-1:0]  t_off_on,
    input  logic [`TDELAY_WIDTH-1:0]  t_on_off_v0,
    input  logic [`TDELAY_WIDTH-1:0]  t_off_on_i0,
    output logic [`STEP_WIDTH-1:0]    step,
    output logic                      done,
    output logic [`GATE_WIDTH-1:0]    gates
);

    logic [`TDELAY_WIDTH-1:0] dly_val;
    logic [`TDELAY_WIDTH-1:0] dwell;
    logic                     step_end;

    always_comb begin
        case (dly_sel)
            DLY_OFF_ON:    dly_val = t_off_on;
            DLY_ON_OFF_V0: dly_val = t_on_off_v0;
            DLY_OFF_ON_I0: dly_val = t_off_on_i0;
            default:       dly_val = t_short;
        endcase
    end

    assign step_end = (dwell == dly_val - 1'b1);  // Last dwell cycle of this step
    assign done     = active && last_step && step_end;

    ////////////////////////////////////////
    // Dwell and step counters, gate register
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dwell <= '0;
            step  <= '0;
            gates <= `GATE_RESET;
        end else begin
            // Counters lead gates by one edge
            gates <= active ? step_gates : steady_gates;
            if (!active || done) begin
                dwell <= '0;
                step  <= '0;
            end else if (step_end) begin
                dwell <= '0;
                step  <= step + 1'b1;
            end else begin
                dwell <= dwell + 1'b1;
            end
        end
    end

endmodule

/* hdl/anpc_commutation_table.sv */
`timescale 1ns/100ps

`include "anpc_defines.svh"

module anpc_commutation_table
    import anpc_state_pkg::*;
    import anpc_seq_pkg::*;
(
    input  anpc_state_t              cur_state,
    input  anpc_state_t              dst_state,
    input  logic [`STEP_WIDTH-1:0]   step,
    output logic [`GATE_WIDTH-1:0]   step_gates,
    output logic [`GATE_WIDTH-1:0]   steady_gates,
    output dly_sel_t                 dly_sel,
    output logic                     last_step
);

    // Gate pattern, delay select, last-step flag
    logic [`GATE_WIDTH+2:0] entry;

    ////////////////////////////////////////
    // Steady patterns
    ////////////////////////////////////////

    always_comb begin
        case (cur_state)
            ST_P:    steady_gates = 6'b110_001;
            ST_ZU2:  steady_gates = 6'b010_010;
            ST_ZU1:  steady_gates = 6'b010_110;
            ST_ZL1:  steady_gates = 6'b101_001;
            ST_ZL2:  steady_gates = 6'b001_001;
            ST_N:    steady_gates = 6'b001_110;
            default: steady_gates = `GATE_RESET;
        endcase
    end

    ////////////////////////////////////////
    // Dead-time sequences
    ////////////////////////////////////////

    always_comb begin
        // Unlisted pairs end after one short step
        entry = {steady_gates, DLY_SHORT, 1'b1};
        case ({cur_state, dst_state})
            {ST_ZU2, ST_P}: begin
                case (step)
                    2'd0: entry = {6'b010_000, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b110_000, DLY_SHORT, 1'b0};
                    2'd2: entry = {6'b110_001, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_ZU2, ST_N}: begin
                case (step)
                    2'd0: entry = {6'b011_010, DLY_SHORT, 1'b0};
                    2'd1: entry = {6'b001_010, DLY_OFF_ON, 1'b0};
                    2'd2: entry = {6'b001_110, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_ZU1, ST_P}: begin
                case (step)
                    2'd0: entry = {6'b010_010, DLY_OFF_ON_I0, 1'b0};
                    2'd1: entry = {6'b010_011, DLY_SHORT, 1'b0};
                    2'd2: entry = {6'b010_001, DLY_OFF_ON, 1'b0};
                    2'd3: entry = {6'b110_001, DLY_SHORT, 1'b1};
                endcase
            end
            {ST_ZU1, ST_N}: begin
                case (step)
                    2'd0: entry = {6'b000_110, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b001_110, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_ZL1, ST_P}: begin
                case (step)
                    2'd0: entry = {6'b100_001, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b110_001, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_ZL1, ST_N}: begin
                case (step)
                    2'd0: entry = {6'b001_001, DLY_OFF_ON_I0, 1'b0};
                    2'd1: entry = {6'b001_011, DLY_SHORT, 1'b0};
                    2'd2: entry = {6'b001_010, DLY_OFF_ON, 1'b0};
                    2'd3: entry = {6'b001_110, DLY_SHORT, 1'b1};
                endcase
            end
            {ST_ZL2, ST_P}: begin
                case (step)
                    2'd0: entry = {6'b011_001, DLY_SHORT, 1'b0};
                    2'd1: entry = {6'b010_001, DLY_OFF_ON, 1'b0};
                    2'd2: entry = {6'b110_001, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_ZL2, ST_N}: begin
                case (step)
                    2'd0: entry = {6'b001_000, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b001_100, DLY_SHORT, 1'b0};
                    2'd2: entry = {6'b001_110, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_P, ST_ZU2}: begin  // Type I
                case (step)
                    2'd0: entry = {6'b110_000, DLY_SHORT, 1'b0};
                    2'd1: entry = {6'b010_000, DLY_OFF_ON, 1'b0};
                    2'd2: entry = {6'b010_010, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_P, ST_ZL1}: begin  // Type III
                case (step)
                    2'd0: entry = {6'b100_001, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b101_001, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_P, ST_ZL2}: begin  // Type II
                case (step)
                    2'd0: entry = {6'b010_001, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b011_001, DLY_SHORT, 1'b0};
                    2'd2: entry = {6'b001_001, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_N, ST_ZU2}: begin  // Type II
                case (step)
                    2'd0: entry = {6'b001_010, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b011_010, DLY_ON_OFF_V0, 1'b0};
                    2'd2: entry = {6'b010_010, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_N, ST_ZU1}: begin  // Type III
                case (step)
                    2'd0: entry = {6'b000_110, DLY_OFF_ON, 1'b0};
                    2'd1: entry = {6'b010_110, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            {ST_N, ST_ZL2}: begin  // Type I
                case (step)
                    2'd0: entry = {6'b001_100, DLY_SHORT, 1'b0};
                    2'd1: entry = {6'b001_000, DLY_OFF_ON, 1'b0};
                    2'd2: entry = {6'b001_001, DLY_SHORT, 1'b1};
                    default: ;
                endcase
            end
            default: entry = {steady_gates, DLY_SHORT, 1'b1};
        endcase
    end

    assign step_gates = entry[`GATE_WIDTH+2:3];
    assign dly_sel    = dly_sel_t'(entry[2:1]);
    assign last_step  = entry[0];

endmodule

/* hdl/anpc_defines.svh */
`ifndef ANPC_DEFINES_SVH
`define ANPC_DEFINES_SVH

// Delay inputs and dwell counter
`define TDELAY_WIDTH 8

// Six switches per leg
`define GATE_WIDTH 6

// Longest dead-time sequence has four steps
`define STEP_WIDTH 2

// ZU2 steady pattern, the safe state out of reset
`define GATE_RESET 6'b010_010

`endif

/* hdl/anpc_gate_ctrl_top.sv */
`timescale 1ns/100ps

`include "anpc_defines.svh"

module anpc_gate_ctrl_top
    import anpc_state_pkg::*;
    import anpc_seq_pkg::*;
(
    input  logic                      clk,
    input  logic                      rst,
    input  logic [`TDELAY_WIDTH-1:0]  t_short,
    input  logic [`TDELAY_WIDTH-1:0]  t_off_on,
    input  logic [`TDELAY_WIDTH-1:0]  t_on_off_v0,
    input  logic [`TDELAY_WIDTH-1:0]  t_off_on_i0,
    input  level_t                    lev,
    input  comm_type_t                comm_type,
    output logic [`GATE_WIDTH-1:0]    gates
);

    anpc_state_t              cur_state;
    anpc_state_t              dst_state;
    logic                     active;
    logic                     done;
    logic [`STEP_WIDTH-1:0]   step;
    logic [`GATE_WIDTH-1:0]   step_gates;
    logic [`GATE_WIDTH-1:0]   steady_gates;
    dly_sel_t                 dly_sel;
    logic                     last_step;

    anpc_level_fsm u_level_fsm (
        .clk       (clk),
        .rst       (rst),
        .lev       (lev),
        .comm_type (comm_type),
        .done      (done),
        .cur_state (cur_state),
        .dst_state (dst_state),
        .active    (active)
    );

    anpc_commutation_table u_comm_table (
        .cur_state    (cur_state),
        .dst_state    (dst_state),
        .step         (step),
        .step_gates   (step_gates),
        .steady_gates (steady_gates),
        .dly_sel      (dly_sel),
        .last_step    (last_step)
    );

    anpc_commutation_seq u_comm_seq (
        .clk          (clk),
        .rst          (rst),
        .active       (active),
        .step_gates   (step_gates),
        .steady_gates (steady_gates),
        .dly_sel      (dly_sel),
        .last_step    (last_step),
        .t_short      (t_short),
        .t_off_on     (t_off_on),
        .t_on_off_v0  (t_on_off_v0),
        .t_off_on_i0  (t_off_on_i0),
        .step         (step),
        .done         (done),
        .gates        (gates)
    );

endmodule

/* hdl/anpc_level_fsm.sv */
`timescale 1ns/100ps

module anpc_level_fsm
    import anpc_state_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  level_t      lev,
    input  comm_type_t  comm_type,
    input  logic        done,
    output anpc_state_t cur_state,
    output anpc_state_t dst_state,
    output logic        active
);

    anpc_state_t target;

    ////////////////////////////////////////
    // Target state selection
    ////////////////////////////////////////

    always_comb begin
        target = cur_state;
        case (cur_state)
            ST_ZU2, ST_ZU1, ST_ZL1, ST_ZL2: begin
                if (lev == LEV_POS) begin
                    target = ST_P;
                end else if (lev == LEV_NEG) begin
                    target = ST_N;
                end
            end
            ST_P: begin
                if (lev == LEV_ZERO) begin
                    case (comm_type)
                        COMM_II:  target = ST_ZL2;
                        COMM_III: target = ST_ZL1;
                        default:  target = ST_ZU2;  // Type I and unused codes
                    endcase
                end
            end
            ST_N: begin
                if (lev == LEV_ZERO) begin
                    case (comm_type)
                        COMM_II:  target = ST_ZU2;
                        COMM_III: target = ST_ZU1;
                        default:  target = ST_ZL2;
                    endcase
                end
            end
            default: target = cur_state;
        endcase
    end

    ////////////////////////////////////////
    // Commutation start and commit
    ////////////////////////////////////////

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cur_state <= ST_ZU2;
            dst_state <= ST_ZU2;
            active    <= 1'b0;
        end else if (active) begin
            if (done) begin  // Last dead-time step over
                cur_state <= dst_state;
                active    <= 1'b0;
            end
        end else if (target != cur_state) begin
            dst_state <= target;
            active    <= 1'b1;
        end
    end

endmodule

/* hdl/anpc_seq_pkg.sv */
package anpc_seq_pkg;

    // Which programmable delay a dead-time step waits for
    typedef enum logic [1:0] {
        DLY_SHORT     = 2'd0,
        DLY_OFF_ON    = 2'd1,
        DLY_ON_OFF_V0 = 2'd2,  // Only N to ZU2
        DLY_OFF_ON_I0 = 2'd3   // Four-step sequences into P and N
    } dly_sel_t;

endpackage

/* hdl/anpc_state_pkg.sv */
package anpc_state_pkg;

    // Requested output level, code 3 keeps the present state
    typedef enum logic [1:0] {
        LEV_ZERO = 2'd0,
        LEV_POS  = 2'd1,
        LEV_NEG  = 2'd2
    } level_t;

    // Commutation type from the thermal balancing logic
    typedef enum logic [1:0] {
        COMM_I   = 2'd0,
        COMM_II  = 2'd1,
        COMM_III = 2'd2
    } comm_type_t;

    typedef enum logic [2:0] {
        ST_P   = 3'd0,
        ST_ZU2 = 3'd1,  // Upper zero paths
        ST_ZU1 = 3'd2,
        ST_ZL1 = 3'd3,  // Lower zero paths
        ST_ZL2 = 3'd4,
        ST_N   = 3'd5
    } anpc_state_t;

endpackage

/* run_sim.sh */
#!/bin/sh
# Compile with Verilator, run the testbench, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -f sim.f --top-module tb_anpc -o tb_anpc \
    && ./obj_dir/tb_anpc > sim.log 2>&1 \
    || echo "compile or run ended with an error"
grep -q "SIMULATION PASSED" sim.log || { echo "run failed, see sim.log"; exit 1; }
echo "run passed"

/* sim.f */
+incdir+hdl
+incdir+dv
hdl/anpc_state_pkg.sv
hdl/anpc_seq_pkg.sv
hdl/anpc_level_fsm.sv
hdl/anpc_commutation_table.sv
hdl/anpc_commutation_seq.sv
hdl/anpc_gate_ctrl_top.sv
dv/tb_anpc.sv
